/* common/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// 640x480 at 60 Hz, counts in pixel clocks
`define BOARD_H_ACTIVE 10'd640
`define BOARD_H_FRONT  10'd16
`define BOARD_H_SYNC   10'd96
`define BOARD_H_TOTAL  10'd800

// counts in lines
`define BOARD_V_ACTIVE 10'd480
`define BOARD_V_FRONT  10'd10
`define BOARD_V_SYNC   10'd2
`define BOARD_V_TOTAL  10'd525

// start, 8 data, parity, stop
`define BOARD_PS2_FRAME_BITS 4'd11

`define BOARD_SEG_BLANK 8'hff

`endif

/* common/board_pkg.sv */
package board_pkg;

    // alu function select, encoding follows the board switches
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_not = 3'd2,
        op_and = 3'd3,
        op_or  = 3'd4,
        op_xor = 3'd5,
        op_lt  = 3'd6,
        op_eq  = 3'd7
    } alu_op_e;

    // active low segments, {dp, g, f, e, d, c, b, a}
    typedef logic [7:0] seg_pattern_t;

endpackage

/* ps2_keyboard/ps2_keyboard.sv */
`include "board_macros.svh"

module ps2_keyboard (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       key_ready,
    output logic       key_valid,
    output logic [7:0] key_code,
    output logic [7:0] last_code,
    output logic       key_overflow
);

    logic [2:0] clk_sync;
    logic [1:0] data_sync;
    logic       ps2_fall;
    logic [3:0] bit_cnt;
    logic [9:0] frame;
    logic       frame_end;
    logic       frame_good;
    logic       out_free;

    // two stage sync, third stage of clk_sync only for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign ps2_fall = clk_sync[2] & ~clk_sync[1];

    // stop bit is checked live, never stored
    assign frame_end  = ps2_fall && (bit_cnt == `BOARD_PS2_FRAME_BITS - 4'd1);
    assign frame_good = ~frame[0] & data_sync[1] & (^frame[9:1]);
    assign out_free   = ~key_valid | key_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= 4'd0;
        end else if (frame_end) begin
            bit_cnt <= 4'd0;
        end else if (ps2_fall) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // frame[0] start, frame[8:1] data lsb first, frame[9] parity
    always_ff @(posedge clk) begin
        if (ps2_fall && !frame_end) begin
            frame[bit_cnt] <= data_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end && frame_good && out_free) begin
            key_code <= frame[8:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_valid    <= 1'b0;
            key_overflow <= 1'b0;
            last_code    <= 8'h00;
        end else begin
            if (key_valid && key_ready) begin
                key_valid <= 1'b0;
            end
            if (frame_end && frame_good) begin
                if (out_free) begin
                    key_valid <= 1'b1;
                    last_code <= frame[8:1];
                end else begin
                    // held code wins, new one is lost
                    key_overflow <= 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/alu_4bit.sv */
module alu_4bit (
    input  board_pkg::alu_op_e alu_fnselec,
    input  logic [3:0]         alu_a,
    input  logic [3:0]         alu_b,
    output logic [3:0]         alu_res,
    output logic               alu_zero,
    output logic               alu_overflow,
    output logic               alu_carry
);

    import board_pkg::*;

    logic       is_sub;
    logic [3:0] b_eff;
    logic [4:0] sum;
    logic       sum_ovf;

    // sub is a + ~b + 1
    assign is_sub  = (alu_fnselec == op_sub);
    assign b_eff   = is_sub ? ~alu_b : alu_b;
    assign sum     = {1'b0, alu_a} + {1'b0, b_eff} + {4'd0, is_sub};
    assign sum_ovf = (alu_a[3] == b_eff[3]) && (sum[3] != alu_a[3]);

    always_comb begin
        alu_res      = 4'd0;
        alu_carry    = 1'b0;
        alu_overflow = 1'b0;
        case (alu_fnselec)
            op_add, op_sub: begin
                alu_res      = sum[3:0];
                alu_carry    = sum[4];
                alu_overflow = sum_ovf;
            end
            op_not: alu_res = ~alu_a;
            op_and: alu_res = alu_a & alu_b;
            op_or:  alu_res = alu_a | alu_b;
            op_xor: alu_res = alu_a ^ alu_b;
            op_lt:  alu_res = {3'd0, $signed(alu_a) < $signed(alu_b)};
            op_eq:  alu_res = {3'd0, alu_a == alu_b};
            default: alu_res = 4'd0;
        endcase
    end

    assign alu_zero = (alu_res == 4'd0);

endmodule

/* rtl/top.sv */
module top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              sw,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    input  logic                    key_ready,
    input  board_pkg::alu_op_e      alu_fnselec,
    input  logic [3:0]              alu_a,
    input  logic [3:0]              alu_b,
    output logic                    key_valid,
    output logic [7:0]              key_code,
    output logic                    key_overflow,
    output logic                    VGA_CLK,
    output logic                    VGA_HSYNC,
    output logic                    VGA_VSYNC,
    output logic                    VGA_BLANK_N,
    output logic [7:0]              VGA_R,
    output logic [7:0]              VGA_G,
    output logic [7:0]              VGA_B,
    output board_pkg::seg_pattern_t seg0,
    output board_pkg::seg_pattern_t seg1,
    output board_pkg::seg_pattern_t seg2,
    output board_pkg::seg_pattern_t seg3,
    output board_pkg::seg_pattern_t seg4,
    output board_pkg::seg_pattern_t seg5,
    output board_pkg::seg_pattern_t seg6,
    output board_pkg::seg_pattern_t seg7,
    output logic [3:0]              alu_res,
    output logic                    alu_zero,
    output logic                    alu_overflow,
    output logic                    alu_carry
);

    logic [7:0] last_code;

    // pixel clock is the board clock
    assign VGA_CLK = clk;

    ps2_keyboard u_keyboard (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_ready    (key_ready),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .last_code    (last_code),
        .key_overflow (key_overflow)
    );

    alu_4bit u_alu (
        .alu_fnselec  (alu_fnselec),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_res      (alu_res),
        .alu_zero     (alu_zero),
        .alu_overflow (alu_overflow),
        .alu_carry    (alu_carry)
    );

    // display keeps the code after the handshake
    seg_display u_seg (
        .clk            (clk),
        .rst_n          (rst_n),
        .sw             (sw),
        .key_code_shown (last_code),
        .alu_res        (alu_res),
        .seg0           (seg0),
        .seg1           (seg1),
        .seg2           (seg2),
        .seg3           (seg3),
        .seg4           (seg4),
        .seg5           (seg5),
        .seg6           (seg6),
        .seg7           (seg7)
    );

    vga_ctrl u_vga (
        .clk     (clk),
        .rst_n   (rst_n),
        .hsync   (VGA_HSYNC),
        .vsync   (VGA_VSYNC),
        .blank_n (VGA_BLANK_N),
        .vga_r   (VGA_R),
        .vga_g   (VGA_G),
        .vga_b   (VGA_B)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top -f sim.f -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation finished, see sim.log"

/* seg/seg_display.sv */
`include "board_macros.svh"

module seg_display (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              sw,
    input  logic [7:0]              key_code_shown,
    input  logic [3:0]              alu_res,
    output board_pkg::seg_pattern_t seg0,
    output board_pkg::seg_pattern_t seg1,
    output board_pkg::seg_pattern_t seg2,
    output board_pkg::seg_pattern_t seg3,
    output board_pkg::seg_pattern_t seg4,
    output board_pkg::seg_pattern_t seg5,
    output board_pkg::seg_pattern_t seg6,
    output board_pkg::seg_pattern_t seg7
);

    import board_pkg::*;

    logic [2:0] sw_idx;
    logic       sw_any;

    function automatic seg_pattern_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

    // highest set switch wins
    always_comb begin
        sw_idx = 3'd0;
        sw_any = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (sw[i]) begin
                sw_idx = 3'(i);
                sw_any = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg0 <= `BOARD_SEG_BLANK;
            seg1 <= `BOARD_SEG_BLANK;
            seg2 <= `BOARD_SEG_BLANK;
            seg3 <= `BOARD_SEG_BLANK;
            seg4 <= `BOARD_SEG_BLANK;
            seg5 <= `BOARD_SEG_BLANK;
            seg6 <= `BOARD_SEG_BLANK;
            seg7 <= `BOARD_SEG_BLANK;
        end else begin
            seg0 <= hex_to_seg(key_code_shown[3:0]);
            seg1 <= hex_to_seg(key_code_shown[7:4]);
            seg2 <= hex_to_seg(alu_res);
            seg3 <= sw_any ? hex_to_seg({1'b0, sw_idx}) : `BOARD_SEG_BLANK;
            // decimal point alone marks encoder valid
            seg4 <= sw_any ? 8'h7f : `BOARD_SEG_BLANK;
            seg5 <= `BOARD_SEG_BLANK;
            seg6 <= `BOARD_SEG_BLANK;
            seg7 <= `BOARD_SEG_BLANK;
        end
    end

endmodule

/* sim.f */
+incdir+common
common/board_pkg.sv
rtl/alu_4bit.sv
ps2_keyboard/ps2_keyboard.sv
seg/seg_display.sv
vga/vga_ctrl.sv
rtl/top.sv
verification/top_props.sv
verification/tb_top.sv

/* verification/tb_top.sv */
`include "board_macros.svh"

module tb_top;

    import board_pkg::*;

    localparam int cycle_limit = 25000;
    localparam int h_active = int'(`BOARD_H_ACTIVE);
    localparam int h_sync_start = int'(`BOARD_H_ACTIVE + `BOARD_H_FRONT);
    localparam int h_sync = int'(`BOARD_H_SYNC);
    localparam int h_total = int'(`BOARD_H_TOTAL);
    localparam int frame_bits = int'(`BOARD_PS2_FRAME_BITS);
    localparam logic [7:0] seg_blank = `BOARD_SEG_BLANK;
    // standard active low hex digits with dp in bit 7
    localparam logic [7:0] hex_segs [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92,
        8'h82, 8'hf8, 8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

    logic         clk, rst_n, ps2_clk, ps2_data, key_ready;
    logic [7:0]   sw;
    alu_op_e      alu_fnselec;
    logic [3:0]   alu_a, alu_b, alu_res;
    logic         key_valid, key_overflow, alu_zero, alu_overflow, alu_carry;
    logic [7:0]   key_code, vga_r, vga_g, vga_b;
    logic         vga_clk, hsync, vsync, blank_n;
    seg_pattern_t seg [8];
    int           cycle_count = 0;
    int           check_count = 0;
    int           error_count = 0;

    top uut (
        .clk (clk), .rst_n (rst_n), .sw (sw), .ps2_clk (ps2_clk), .ps2_data (ps2_data),
        .key_ready (key_ready), .alu_fnselec (alu_fnselec), .alu_a (alu_a), .alu_b (alu_b),
        .key_valid (key_valid), .key_code (key_code), .key_overflow (key_overflow),
        .VGA_CLK (vga_clk), .VGA_HSYNC (hsync), .VGA_VSYNC (vsync), .VGA_BLANK_N (blank_n),
        .VGA_R (vga_r), .VGA_G (vga_g), .VGA_B (vga_b),
        .seg0 (seg[0]), .seg1 (seg[1]), .seg2 (seg[2]), .seg3 (seg[3]),
        .seg4 (seg[4]), .seg5 (seg[5]), .seg6 (seg[6]), .seg7 (seg[7]),
        .alu_res (alu_res), .alu_zero (alu_zero), .alu_overflow (alu_overflow),
        .alu_carry (alu_carry)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d clock cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_cycle;
        @(posedge clk);
        #2;
    endtask

    // data changes while ps2_clk is high and the host samples on the fall
    task automatic ps2_send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < frame_bits; i++) begin
            ps2_data = bits[i];
            repeat (8) wait_cycle();
            ps2_clk = 1'b0;
            repeat (8) wait_cycle();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic wait_for_valid;
        int waited = 0;
        while (!key_valid && waited < 100) begin
            wait_cycle();
            waited++;
        end
        if (!key_valid) begin
            error_count++;
            $display("key_valid did not rise within 100 cycles after a good frame");
        end
    endtask

    task automatic test_reset_state;
        check_value("key_valid", 0, 32'(key_valid));
        check_value("key_overflow", 0, 32'(key_overflow));
        check_value("hsync", 1, 32'(hsync));
        check_value("vsync", 1, 32'(vsync));
        check_value("blank_n", 1, 32'(blank_n));
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("seg%0d", i), 32'(seg_blank), 32'(seg[i]));
        end
    endtask

    // h count equals n at each sample of the first line after reset release
    task automatic test_vga_line;
        int low_count = 0;
        int first_low = -1;
        int blank_high = 0;
        logic [2:0] bars;
        for (int n = 0; n < h_total; n++) begin
            if (!hsync) begin
                low_count++;
                if (first_low < 0) first_low = n;
            end
            if (blank_n) blank_high++;
            if (n % 16 == 0 || n % 16 == 15) begin
                bars = (n < h_active) ? 3'(n >> 7) : 3'b000;
                check_value("vga_r", bars[2] ? 32'hff : 32'h0, 32'(vga_r));
                check_value("vga_g", bars[1] ? 32'hff : 32'h0, 32'(vga_g));
                check_value("vga_b", bars[0] ? 32'hff : 32'h0, 32'(vga_b));
            end
            wait_cycle();
        end
        check_value("hsync low cycles", h_sync, low_count);
        check_value("hsync first low", h_sync_start, first_low);
        check_value("blank_n high cycles", h_active, blank_high);
    endtask

    // pixel clock follows the board clock in both phases
    task automatic check_vga_clock;
        check_value("vga_clk", 1, 32'(vga_clk));
        @(negedge clk);
        #2;
        check_value("vga_clk", 0, 32'(vga_clk));
        wait_cycle();
    endtask

    task automatic test_key_handshake;
        logic [7:0] code = 8'h1c;
        key_ready = 1'b0;
        ps2_send_frame(code, 1'b0);
        wait_for_valid();
        check_value("key_code", 32'(code), 32'(key_code));
        repeat (20) begin
            wait_cycle();
            check_value("key_valid", 1, 32'(key_valid));
            check_value("key_code", 32'(code), 32'(key_code));
        end
        key_ready = 1'b1;
        wait_cycle();
        key_ready = 1'b0;
        check_value("key_valid", 0, 32'(key_valid));
        check_value("seg0", 32'(hex_segs[code[3:0]]), 32'(seg[0]));
        check_value("seg1", 32'(hex_segs[code[7:4]]), 32'(seg[1]));
    endtask

    task automatic test_key_errors;
        ps2_send_frame(8'h2a, 1'b1);
        repeat (10) begin
            wait_cycle();
            check_value("key_valid", 0, 32'(key_valid));
        end
        check_value("key_overflow", 0, 32'(key_overflow));
        ps2_send_frame(8'h33, 1'b0);
        wait_for_valid();
        ps2_send_frame(8'h44, 1'b0);
        wait_cycle();
        check_value("key_overflow", 1, 32'(key_overflow));
        check_value("key_valid", 1, 32'(key_valid));
        check_value("key_code", 32'h33, 32'(key_code));
        key_ready = 1'b1;
        wait_cycle();
        key_ready = 1'b0;
        // overflow stays set after the handshake
        check_value("key_overflow", 1, 32'(key_overflow));
    endtask

    task automatic apply_alu(input alu_op_e op, input logic [3:0] a, input logic [3:0] b);
        int sa, sb, full;
        logic [3:0] res;
        logic carry, ovf;
        sa = a[3] ? int'(a) - 16 : int'(a);
        sb = b[3] ? int'(b) - 16 : int'(b);
        full = 0;
        carry = 1'b0;
        ovf = 1'b0;
        case (op)
            op_add: begin
                full = int'(a) + int'(b);
                ovf = (sa + sb > 7) || (sa + sb < -8);
            end
            op_sub: begin
                full = int'(a) + int'(b ^ 4'hf) + 1;
                ovf = (sa - sb > 7) || (sa - sb < -8);
            end
            op_not: full = int'(~a);
            op_and: full = int'(a & b);
            op_or:  full = int'(a | b);
            op_xor: full = int'(a ^ b);
            op_lt:  full = (sa < sb) ? 1 : 0;
            default: full = (a == b) ? 1 : 0;
        endcase
        res = full[3:0];
        if (op == op_add || op == op_sub) carry = full[4];
        alu_fnselec = op;
        alu_a = a;
        alu_b = b;
        wait_cycle();
        check_value($sformatf("alu_res op%0d", op), 32'(res), 32'(alu_res));
        check_value("alu_zero", 32'(res == 4'd0), 32'(alu_zero));
        check_value("alu_overflow", 32'(ovf), 32'(alu_overflow));
        check_value("alu_carry", 32'(carry), 32'(alu_carry));
        check_value("seg2", 32'(hex_segs[res]), 32'(seg[2]));
    endtask

    task automatic test_alu;
        for (int op = 0; op < 8; op++) begin
            apply_alu(alu_op_e'(op), 4'd7, 4'd1);
            apply_alu(alu_op_e'(op), 4'd8, 4'd1);
            apply_alu(alu_op_e'(op), 4'd15, 4'd1);
            apply_alu(alu_op_e'(op), 4'd0, 4'd0);
            repeat (4) apply_alu(alu_op_e'(op), 4'($urandom), 4'($urandom));
        end
    endtask

    task automatic test_switch_encoder;
        logic [7:0] patterns [8];
        int top_bit;
        patterns = '{8'h00, 8'h01, 8'h80, 8'h12, 8'h3c, 8'h05, 8'hff, 8'h40};
        for (int p = 0; p < 8; p++) begin
            sw = patterns[p];
            top_bit = -1;
            for (int i = 7; i >= 0; i--) begin
                if (patterns[p][i] && top_bit < 0) top_bit = i;
            end
            wait_cycle();
            if (top_bit < 0) begin
                check_value("seg3", 32'(seg_blank), 32'(seg[3]));
                check_value("seg4", 32'(seg_blank), 32'(seg[4]));
            end else begin
                check_value("seg3", 32'(hex_segs[top_bit[3:0]]), 32'(seg[3]));
                check_value("seg4", 32'(seg_blank & ~8'h80), 32'(seg[4]));
            end
        end
        for (int i = 5; i < 8; i++) begin
            check_value($sformatf("seg%0d", i), 32'(seg_blank), 32'(seg[i]));
        end
    endtask

    initial begin
        void'($urandom(32'h104201b3));
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        key_ready = 1'b0;
        sw = 8'h00;
        alu_fnselec = op_add;
        alu_a = 4'd0;
        alu_b = 4'd0;
        repeat (10) wait_cycle();
        test_reset_state();
        rst_n = 1'b1;
        test_vga_line();
        test_key_handshake();
        test_key_errors();
        test_alu();
        test_switch_encoder();
        check_vga_clock();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verification/top_props.sv */
module top_props (
    input logic       clk,
    input logic       rst_n,
    input logic       key_valid,
    input logic       key_ready,
    input logic [7:0] key_code,
    input logic       hsync,
    input logic       blank_n,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b
);

    // held code stays until taken
    hold_code: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid && !key_ready |=> key_valid && $stable(key_code))
        else $error("key_code or key_valid moved while waiting for key_ready");

    sync_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !hsync |-> !blank_n)
        else $error("hsync pulse inside the active area");

    dark_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !blank_n |-> (vga_r == 8'd0 && vga_g == 8'd0 && vga_b == 8'd0))
        else $error("colour output not zero during blanking");

endmodule

bind top top_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .key_valid (key_valid),
    .key_ready (key_ready),
    .key_code  (key_code),
    .hsync     (VGA_HSYNC),
    .blank_n   (VGA_BLANK_N),
    .vga_r     (VGA_R),
    .vga_g     (VGA_G),
    .vga_b     (VGA_B)
);

/* vga/vga_ctrl.sv */
`include "board_macros.svh"

module vga_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    output logic       hsync,
    output logic       vsync,
    output logic       blank_n,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_wrap;
    logic       v_wrap;
    logic       active;

    assign h_wrap = (h_cnt == `BOARD_H_TOTAL - 10'd1);
    assign v_wrap = (v_cnt == `BOARD_V_TOTAL - 10'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= 10'd0;
        end else if (h_wrap) begin
            h_cnt <= 10'd0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt <= 10'd0;
        end else if (h_wrap) begin
            v_cnt <= v_wrap ? 10'd0 : v_cnt + 10'd1;
        end
    end

    // sync pulses sit after the front porch, active low
    assign hsync = !((h_cnt >= `BOARD_H_ACTIVE + `BOARD_H_FRONT) &&
                     (h_cnt <  `BOARD_H_ACTIVE + `BOARD_H_FRONT + `BOARD_H_SYNC));
    assign vsync = !((v_cnt >= `BOARD_V_ACTIVE + `BOARD_V_FRONT) &&
                     (v_cnt <  `BOARD_V_ACTIVE + `BOARD_V_FRONT + `BOARD_V_SYNC));

    assign active  = (h_cnt < `BOARD_H_ACTIVE) && (v_cnt < `BOARD_V_ACTIVE);
    assign blank_n = active;

    // colour bars, 128 pixels wide
    assign vga_r = {8{active & h_cnt[9]}};
    assign vga_g = {8{active & h_cnt[8]}};
    assign vga_b = {8{active & h_cnt[7]}};

endmodule
